// File: include/sincos_settings.svh
`ifndef SINCOS_SETTINGS_SVH
`define SINCOS_SETTINGS_SVH

// ********************************************************************
// sizes shared by the generator and its test environment.
// ********************************************************************

// quarter-wave cosine entries, one per 6-bit angle.
`define SINCOS_TABLE_DEPTH 64

// result fifo slots.
// also the phase credits a source holds after reset.
`define SINCOS_FIFO_DEPTH 4

// ceiling on outstanding sample credits from the sink.
`define SINCOS_CREDIT_MAX 7

`endif

// File: design/sincos_pkg.sv
// ********************************************************************
// vector types of the sine and cosine generator.
// ********************************************************************

package sincos_pkg;

    // phase word.
    // [7:6] quadrant, [5:0] angle inside the quadrant.
    typedef logic [7:0] phase_t;

    // address of one quarter-wave entry.
    typedef logic [5:0] tbl_index_t;

    // unsigned table entry.
    // full scale is 255.
    typedef logic [7:0] magnitude_t;

    // whole table on one flat bus.
    // entry k occupies bits 8k+7 down to 8k.
    typedef logic [511:0] table_bus_t;

    // signed output sample.
    // one bit wider than a magnitude so -255 fits.
    typedef logic signed [8:0] sample_t;

    // credit and fill counts.
    // wide enough for the largest credit total.
    typedef logic [2:0] credit_t;

endpackage

// File: design/cosine.sv
// ********************************************************************
// quarter-wave entry select.
// ********************************************************************

module cosine (
    input  sincos_pkg::tbl_index_t cos_index,
    input  sincos_pkg::table_bus_t cos_table,
    output sincos_pkg::magnitude_t cos_value
);

    // bits per entry.
    localparam int entry_w = $bits(sincos_pkg::magnitude_t);

    // entries carried by the flat bus.
    localparam int num_entries = $bits(sincos_pkg::table_bus_t) / entry_w;

    // plain mux over all entries.
    // purely combinational, the caller registers the result.
    always_comb begin
        // default keeps the mux free of latches.
        cos_value = '0;
        for (int k = 0; k < num_entries; k++) begin
            // entry k sits at bit offset k * entry_w.
            if (cos_index == sincos_pkg::tbl_index_t'(k)) begin
                cos_value = cos_table[k*entry_w +: entry_w];
            end
        end
    end

endmodule

// File: design/phase_decode.sv
// ********************************************************************
// decode stage.
// folds a phase word into table indices and sign flags.
// ********************************************************************

module phase_decode (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   phase_valid,
    input  sincos_pkg::phase_t     phase,
    output logic                   dec_valid,
    output sincos_pkg::tbl_index_t cos_index,
    output sincos_pkg::tbl_index_t sin_index,
    output logic                   cos_neg,
    output logic                   sin_neg
);

    // quadrant and angle fields.
    logic [1:0]             quadrant;
    sincos_pkg::tbl_index_t angle;
    sincos_pkg::tbl_index_t mirror;

    assign quadrant = phase[7:6];
    assign angle    = phase[5:0];

    // 63 - a is just the bitwise complement.
    assign mirror = ~angle;

    // folding rule.
    //   q0  cos +T[a]  sin +T[m]
    //   q1  cos -T[m]  sin +T[a]
    //   q2  cos -T[a]  sin -T[m]
    //   q3  cos +T[m]  sin -T[a]
    // odd quadrants swap angle and mirror.
    // cosine is negative in q1 and q2, sine in q2 and q3.

    // valid bit.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= phase_valid;
        end
    end

    // indices and signs, loaded with each accepted phase.
    always_ff @(posedge clk) begin
        if (phase_valid) begin
            cos_index <= quadrant[0] ? mirror : angle;
            sin_index <= quadrant[0] ? angle : mirror;
            cos_neg   <= quadrant[0] ^ quadrant[1];
            sin_neg   <= quadrant[1];
        end
    end

endmodule

// File: design/quarter_wave_lookup.sv
`include "sincos_settings.svh"

// ********************************************************************
// execute stage.
// loadable quarter-wave table, two lookups, sign application.
// ********************************************************************

module quarter_wave_lookup (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   tbl_wr,
    input  sincos_pkg::tbl_index_t tbl_addr,
    input  sincos_pkg::magnitude_t tbl_data,
    input  logic                   dec_valid,
    input  sincos_pkg::tbl_index_t cos_index,
    input  sincos_pkg::tbl_index_t sin_index,
    input  logic                   cos_neg,
    input  logic                   sin_neg,
    output logic                   exe_valid,
    output sincos_pkg::sample_t    exe_cos,
    output sincos_pkg::sample_t    exe_sin
);

    // table registers.
    sincos_pkg::magnitude_t tbl_q [`SINCOS_TABLE_DEPTH];

    // flat copy for the select blocks.
    sincos_pkg::table_bus_t table_bus;

    // raw magnitudes from the two lookups.
    sincos_pkg::magnitude_t cos_mag;
    sincos_pkg::magnitude_t sin_mag;

    // magnitudes widened to sample width.
    sincos_pkg::sample_t cos_ext;
    sincos_pkg::sample_t sin_ext;

    // host writes one entry per cycle.
    // new value is seen by lookups from the next cycle on.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < `SINCOS_TABLE_DEPTH; k++) begin
                tbl_q[k] <= '0;
            end
        end else if (tbl_wr) begin
            tbl_q[tbl_addr] <= tbl_data;
        end
    end

    // pack entries, entry 0 at the bottom.
    always_comb begin
        for (int k = 0; k < `SINCOS_TABLE_DEPTH; k++) begin
            table_bus[8*k +: 8] = tbl_q[k];
        end
    end

    cosine i_cos_lut (
        .cos_index (cos_index),
        .cos_table (table_bus),
        .cos_value (cos_mag)
    );

    cosine i_sin_lut (
        .cos_index (sin_index),
        .cos_table (table_bus),
        .cos_value (sin_mag)
    );

    // zero extend, entries are unsigned.
    assign cos_ext = sincos_pkg::sample_t'({1'b0, cos_mag});
    assign sin_ext = sincos_pkg::sample_t'({1'b0, sin_mag});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exe_valid <= 1'b0;
        end else begin
            exe_valid <= dec_valid;
        end
    end

    // signed samples.
    always_ff @(posedge clk) begin
        if (dec_valid) begin
            exe_cos <= cos_neg ? -cos_ext : cos_ext;
            exe_sin <= sin_neg ? -sin_ext : sin_ext;
        end
    end

endmodule

// File: design/sample_output.sv
`include "sincos_settings.svh"

// ********************************************************************
// result stage.
// sample fifo, sink credit counter, send and phase credit return.
// ********************************************************************

module sample_output (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                exe_valid,
    input  sincos_pkg::sample_t exe_cos,
    input  sincos_pkg::sample_t exe_sin,
    input  logic                sample_credit,
    output logic                sample_valid,
    output sincos_pkg::sample_t cos_sample,
    output sincos_pkg::sample_t sin_sample,
    output logic                phase_credit
);

    localparam int ptr_w = $clog2(`SINCOS_FIFO_DEPTH);

    // fifo storage, no reset.
    sincos_pkg::sample_t cos_mem [`SINCOS_FIFO_DEPTH];
    sincos_pkg::sample_t sin_mem [`SINCOS_FIFO_DEPTH];

    logic [ptr_w-1:0]    wr_ptr;
    logic [ptr_w-1:0]    rd_ptr;
    sincos_pkg::credit_t fill;

    // sink credits not yet used by a finished sample.
    sincos_pkg::credit_t out_credits;
    sincos_pkg::credit_t credits_free;

    logic                fifo_avail;
    logic                send_now;
    logic                credit_add;
    sincos_pkg::sample_t head_cos;
    sincos_pkg::sample_t head_sin;

    // an empty fifo passes the incoming sample straight through.
    // this gives the three cycle best case.
    assign fifo_avail = (fill != '0) || exe_valid;
    assign head_cos   = (fill != '0) ? cos_mem[rd_ptr] : exe_cos;
    assign head_sin   = (fill != '0) ? sin_mem[rd_ptr] : exe_sin;

    // a sample on the wire still holds its credit this cycle.
    assign credits_free = out_credits - sincos_pkg::credit_t'(sample_valid);
    assign send_now     = fifo_avail && (credits_free != '0);

    // grants past the ceiling are dropped.
    assign credit_add = sample_credit &&
                        ((out_credits != sincos_pkg::credit_t'(`SINCOS_CREDIT_MAX)) ||
                         sample_valid);

    // ********************************************************************
    // fifo control.
    // ********************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (exe_valid) begin
                wr_ptr <= (wr_ptr == ptr_w'(`SINCOS_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            // bypass moves both pointers, fill stays put.
            if (send_now) begin
                rd_ptr <= (rd_ptr == ptr_w'(`SINCOS_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + sincos_pkg::credit_t'(exe_valid) - sincos_pkg::credit_t'(send_now);
        end
    end

    // storage write.
    always_ff @(posedge clk) begin
        if (exe_valid) begin
            cos_mem[wr_ptr] <= exe_cos;
            sin_mem[wr_ptr] <= exe_sin;
        end
    end

    // ********************************************************************
    // send side.
    // ********************************************************************

    // credit consumed at the end of the sample cycle.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_credits  <= '0;
            sample_valid <= 1'b0;
            phase_credit <= 1'b0;
        end else begin
            out_credits  <= out_credits + sincos_pkg::credit_t'(credit_add) -
                            sincos_pkg::credit_t'(sample_valid);
            sample_valid <= send_now;
            // source gets its slot back with every sample.
            phase_credit <= send_now;
        end
    end

    // sample payload.
    always_ff @(posedge clk) begin
        if (send_now) begin
            cos_sample <= head_cos;
            sin_sample <= head_sin;
        end
    end

endmodule

// File: design/sincos_gen.sv
// ********************************************************************
// sine and cosine generator top.
// decode, execute and result stages in a row.
// ********************************************************************

module sincos_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    // table load.
    input  logic                   tbl_wr,
    input  sincos_pkg::tbl_index_t tbl_addr,
    input  sincos_pkg::magnitude_t tbl_data,
    // phase input.
    input  logic                   phase_valid,
    input  sincos_pkg::phase_t     phase,
    output logic                   phase_credit,
    // sample output.
    input  logic                   sample_credit,
    output logic                   sample_valid,
    output sincos_pkg::sample_t    cos_sample,
    output sincos_pkg::sample_t    sin_sample
);

    // decode to execute.
    logic                   dec_valid;
    sincos_pkg::tbl_index_t cos_index;
    sincos_pkg::tbl_index_t sin_index;
    logic                   cos_neg;
    logic                   sin_neg;

    // execute to result.
    logic                   exe_valid;
    sincos_pkg::sample_t    exe_cos;
    sincos_pkg::sample_t    exe_sin;

    phase_decode i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .phase_valid (phase_valid),
        .phase       (phase),
        .dec_valid   (dec_valid),
        .cos_index   (cos_index),
        .sin_index   (sin_index),
        .cos_neg     (cos_neg),
        .sin_neg     (sin_neg)
    );

    quarter_wave_lookup i_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .tbl_wr    (tbl_wr),
        .tbl_addr  (tbl_addr),
        .tbl_data  (tbl_data),
        .dec_valid (dec_valid),
        .cos_index (cos_index),
        .sin_index (sin_index),
        .cos_neg   (cos_neg),
        .sin_neg   (sin_neg),
        .exe_valid (exe_valid),
        .exe_cos   (exe_cos),
        .exe_sin   (exe_sin)
    );

    sample_output i_result (
        .clk           (clk),
        .rst_n         (rst_n),
        .exe_valid     (exe_valid),
        .exe_cos       (exe_cos),
        .exe_sin       (exe_sin),
        .sample_credit (sample_credit),
        .sample_valid  (sample_valid),
        .cos_sample    (cos_sample),
        .sin_sample    (sin_sample),
        .phase_credit  (phase_credit)
    );

endmodule

// File: verif/sincos_gen_checker.sv
`include "sincos_settings.svh"

// ********************************************************************
// protocol and reset assertions for the generator.
// ********************************************************************

module sincos_gen_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                sample_valid,
    input logic                phase_credit,
    input logic                dec_valid,
    input logic                exe_valid,
    input sincos_pkg::credit_t out_credits,
    input sincos_pkg::credit_t fill,
    input sincos_pkg::sample_t cos_sample,
    input sincos_pkg::sample_t sin_sample
);
    timeunit 1ns;
    timeprecision 1ps;

    // a sample needs a sink credit behind it.
    a_send_needs_credit: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> (out_credits != '0))
        else $error("sample sent with zero output credits");

    // credited source never overfills the fifo.
    a_fifo_bound: assert property (@(posedge clk) disable iff (!rst_n)
        fill <= sincos_pkg::credit_t'(`SINCOS_FIFO_DEPTH))
        else $error("fifo fill above its depth");

    // one phase credit back per sample.
    a_credit_return: assert property (@(posedge clk) disable iff (!rst_n)
        phase_credit == sample_valid)
        else $error("phase credit does not track sample valid");

    // control outputs quiet in reset.
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(sample_valid || phase_credit || dec_valid || exe_valid))
        else $error("control output high during reset");

    // payload fully known when offered.
    a_known_payload: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |-> !$isunknown({cos_sample, sin_sample}))
        else $error("unknown bits on a valid sample");

endmodule

bind sincos_gen sincos_gen_checker i_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .phase_credit (phase_credit),
    .dec_valid    (dec_valid),
    .exe_valid    (exe_valid),
    .out_credits  (i_result.out_credits),
    .fill         (i_result.fill),
    .cos_sample   (cos_sample),
    .sin_sample   (sin_sample)
);

// File: verif/sincos_gen_tb.sv
`include "sincos_settings.svh"

module sincos_gen_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic                   clk;
    logic                   rst_n;
    logic                   tbl_wr;
    sincos_pkg::tbl_index_t tbl_addr;
    sincos_pkg::magnitude_t tbl_data;
    logic                   phase_valid;
    sincos_pkg::phase_t     phase;
    logic                   phase_credit;
    logic                   sample_credit;
    logic                   sample_valid;
    sincos_pkg::sample_t    cos_sample;
    sincos_pkg::sample_t    sin_sample;

    integer seed;
    int     val_errs;
    int     proto_errs;
    int     src_credits;
    int     sink_credits;
    logic   sink_on;
    int     base;

    // quadrant 0 reference for the sign rule.
    sincos_pkg::sample_t q0_cos;
    sincos_pkg::sample_t q0_sin;

    // model table and expected samples, oldest first.
    sincos_pkg::magnitude_t tbl_ref [`SINCOS_TABLE_DEPTH];
    sincos_pkg::sample_t    exp_cos [$];
    sincos_pkg::sample_t    exp_sin [$];
    sincos_pkg::sample_t    got_cos [$];
    sincos_pkg::sample_t    got_sin [$];

    sincos_gen i_dut (.*);

    always #4 clk = ~clk;

    // ********************************************************************
    // reference model and compare tasks.
    // ********************************************************************

    // quadrant folding with m = 63 - a.
    function automatic void ref_sample(input sincos_pkg::phase_t p,
                                       output sincos_pkg::sample_t c,
                                       output sincos_pkg::sample_t s);
        int ta;
        int tm;
        ta = int'(tbl_ref[p[5:0]]);
        tm = int'(tbl_ref[63 - int'(p[5:0])]);
        case (p[7:6])
            2'd0: {c, s} = {sincos_pkg::sample_t'(ta), sincos_pkg::sample_t'(tm)};
            2'd1: {c, s} = {sincos_pkg::sample_t'(-tm), sincos_pkg::sample_t'(ta)};
            2'd2: {c, s} = {sincos_pkg::sample_t'(-ta), sincos_pkg::sample_t'(-tm)};
            default: {c, s} = {sincos_pkg::sample_t'(tm), sincos_pkg::sample_t'(-ta)};
        endcase
    endfunction

    task automatic check_sample(input sincos_pkg::sample_t exp_v,
                                input sincos_pkg::sample_t act_v, input string label);
        if (act_v !== exp_v) begin
            $display("ERR %0t: %s expected %0d got %0d", $time, label, exp_v, act_v);
            val_errs++;
        end
    endtask

    task automatic check_credit(input sincos_pkg::credit_t act_v,
                                input sincos_pkg::credit_t limit, input string label);
        if (act_v > limit) begin
            $display("ERR %0t: %s at %0d above limit %0d", $time, label, act_v, limit);
            val_errs++;
        end
    endtask

    // monitor, compare and sink, all on the rising edge.
    always @(posedge clk) begin
        if (rst_n) begin
            if (phase_credit) src_credits++;
            if (sample_valid) begin
                if (sink_credits == 0) begin
                    $display("sample sent while the sink held no credit");
                    proto_errs++;
                end else begin
                    sink_credits--;
                end
                got_cos.push_back(cos_sample);
                got_sin.push_back(sin_sample);
                if (exp_cos.size() == 0) begin
                    $display("sample arrived with no phase waiting for it");
                    proto_errs++;
                end else begin
                    check_sample(exp_cos.pop_front(), cos_sample, "cosine");
                    check_sample(exp_sin.pop_front(), sin_sample, "sine");
                end
            end
            check_credit(sincos_pkg::credit_t'(src_credits),
                         sincos_pkg::credit_t'(`SINCOS_FIFO_DEPTH), "input credits");
        end
        #1;
        // random grants, never above the ceiling.
        sample_credit = 1'b0;
        if (rst_n && sink_on && sink_credits < `SINCOS_CREDIT_MAX && $random(seed) % 2 != 0) begin
            sample_credit = 1'b1;
            sink_credits++;
        end
    end

    // ********************************************************************
    // stimulus helpers.
    // ********************************************************************

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic write_entry(input int idx, input sincos_pkg::magnitude_t val);
        tbl_wr   = 1'b1;
        tbl_addr = sincos_pkg::tbl_index_t'(idx);
        tbl_data = val;
        tbl_ref[idx] = val;
        step();
        tbl_wr = 1'b0;
    endtask

    // waits for a returned credit, then sends one phase.
    task automatic send_phase(input sincos_pkg::phase_t p);
        sincos_pkg::sample_t c;
        sincos_pkg::sample_t s;
        int                  waited;
        waited = 0;
        while (src_credits == 0 && waited < 300) begin
            step();
            waited++;
        end
        if (src_credits == 0) begin
            $display("timed out waiting for a phase credit");
            proto_errs++;
        end else begin
            ref_sample(p, c, s);
            exp_cos.push_back(c);
            exp_sin.push_back(s);
            phase       = p;
            phase_valid = 1'b1;
            src_credits--;
            step();
            phase_valid = 1'b0;
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_cos.size() != 0 && waited < 500) begin
            step();
            waited++;
        end
        if (exp_cos.size() != 0) begin
            $display("timed out with %0d samples still missing", exp_cos.size());
            proto_errs++;
        end
    endtask

    // ********************************************************************
    // test sequence.
    // ********************************************************************

    initial begin
        seed = 32'h6cf1;
        {clk, rst_n, tbl_wr, tbl_addr, tbl_data, phase_valid, phase, sample_credit} = '0;
        {val_errs, proto_errs, sink_credits} = '0;
        src_credits = `SINCOS_FIFO_DEPTH;
        sink_on = 1'b0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        // quiet after reset.
        repeat (6) begin
            step();
            if (sample_valid || phase_credit) begin
                $display("output active after reset with no phases or credits");
                proto_errs++;
            end
        end
        // random table, full scale at the last entry.
        for (int k = 0; k < `SINCOS_TABLE_DEPTH; k++) begin
            write_entry(k, sincos_pkg::magnitude_t'($random(seed)));
        end
        write_entry(63, 8'hff);
        sink_on = 1'b1;
        // every quadrant, edge angles plus random gaps.
        for (int q = 0; q < 4; q++) begin
            send_phase({q[1:0], 6'd0});
            send_phase({q[1:0], 6'd63});
            send_phase({q[1:0], 6'($random(seed))});
            repeat ($unsigned($random(seed)) % 4) step();
        end
        wait_drain();
        // quadrant 2 mirrors quadrant 0.
        base = got_cos.size();
        send_phase(8'h05);
        send_phase(8'h85);
        wait_drain();
        ref_sample(8'h05, q0_cos, q0_sin);
        check_sample(-q0_cos, got_cos[base+1], "q2 cosine sign");
        check_sample(-q0_sin, got_sin[base+1], "q2 sine sign");
        // back to back stream.
        for (int n = 0; n < 16; n++) send_phase(8'($random(seed)));
        wait_drain();
        // sink stalls, leftover grants are used up first.
        sink_on = 1'b0;
        repeat (2) step();
        for (int n = 0; n < `SINCOS_CREDIT_MAX && sink_credits > exp_cos.size(); n++) begin
            send_phase(8'($random(seed)));
        end
        wait_drain();
        repeat (10) step();
        // fifo absorbs the four credited phases.
        base = got_cos.size();
        for (int n = 0; n < `SINCOS_FIFO_DEPTH; n++) send_phase(8'($random(seed)));
        repeat (12) begin
            step();
            if (sample_valid || phase_credit) begin
                $display("sample or phase credit seen while the sink held no credit");
                proto_errs++;
            end
        end
        sink_on = 1'b1;
        wait_drain();
        repeat (10) step();
        if (got_cos.size() != base + `SINCOS_FIFO_DEPTH) begin
            $display("stalled release gave %0d samples", got_cos.size() - base);
            proto_errs++;
        end
        // rewrite one entry, neighbours must keep their values.
        write_entry(10, tbl_ref[10] ^ 8'h5a);
        send_phase(8'h0a);
        send_phase(8'h75);
        send_phase(8'h0b);
        send_phase(8'h09);
        wait_drain();
        $display("value errors %0d, protocol errors %0d", val_errs, proto_errs);
        if (val_errs == 0 && proto_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sincos_gen.f
+incdir+include
design/sincos_pkg.sv
design/cosine.sv
design/phase_decode.sv
design/quarter_wave_lookup.sv
design/sample_output.sv
design/sincos_gen.sv
verif/sincos_gen_checker.sv
verif/sincos_gen_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the sincos_gen testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module sincos_gen_tb \
    -f sincos_gen.f -o sim_sincos_gen
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_sincos_gen)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
